// ==== tb_stimulus.txt ====
# op addr data: R = read byte address, expect data; W = write byte address, data
# E = error burst, crypto pulse count and txbuf pulse count (all fields hex)
R 0000 4e54535f
R 0004 454e474e
R 0008 302e3031
R 0020 00000001
R 0024 00000000
R 000c 00000000
R 0400 00000000
R 0800 00000000
E 5 3
R 0c80 00000000
R 0c84 00000005
R 0c88 00000000
R 0c8c 00000003
E 7 2
R 0c84 00000005
R 0c8c 00000003
R 0c80 00000000
R 0c84 0000000c
W 0000 ffffffff
W 0020 00000000
W 0c84 12345678
R 0000 4e54535f
R 0020 00000001
R 0c84 0000000c
R 0c88 00000000
R 0c8c 00000005
R 0c90 00000000

// ==== all.f ====
nts_axil_pkg.sv
nts_regmap_pkg.sv
nts_axil_slave.sv
nts_error_counter.sv
nts_api_regs.sv
nts_engine_regs.sv
tb_nts_engine_regs.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the engine register testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
  --timescale 1ns/1ps \
  --top-module tb_nts_engine_regs \
  -Mdir obj_dir \
  -f all.f

./obj_dir/Vtb_nts_engine_regs

// ==== tb_nts_engine_regs.sv ====
// Testbench for the NTS engine register block
// Runs the operations of tb_stimulus.txt over AXI4-Lite with random back-pressure
`timescale 1ns/1ps

module tb_nts_engine_regs;

  localparam int TIMEOUT_CYCLES = 50;

  logic                      clk;
  logic                      areset;
  logic                      awvalid;
  logic                      awready;
  nts_axil_pkg::axil_aw_t    aw;
  logic                      wvalid;
  logic                      wready;
  nts_axil_pkg::axil_w_t     w;
  logic                      bvalid;
  logic                      bready;
  nts_axil_pkg::axil_b_t     b;
  logic                      arvalid;
  logic                      arready;
  nts_axil_pkg::axil_addr_t  araddr;
  logic                      rvalid;
  logic                      rready;
  nts_axil_pkg::axil_r_t     r;
  logic                      crypto_error;
  logic                      txbuf_error;

  logic [31:0] rng_state;
  logic [7:0]  op_q[$];     // Operation letter per stimulus line
  logic [31:0] arg_a_q[$];
  logic [31:0] arg_b_q[$];

  nts_engine_regs #(
    .AXI_ADDR_WIDTH(14)
  ) UUT (
    .i_clk          (clk),
    .i_areset       (areset),
    .i_awvalid      (awvalid),
    .o_awready      (awready),
    .i_aw           (aw),
    .i_wvalid       (wvalid),
    .o_wready       (wready),
    .i_w            (w),
    .o_bvalid       (bvalid),
    .i_bready       (bready),
    .o_b            (b),
    .i_arvalid      (arvalid),
    .o_arready      (arready),
    .i_araddr       (araddr),
    .o_rvalid       (rvalid),
    .i_rready       (rready),
    .o_r            (r),
    .i_crypto_error (crypto_error),
    .i_txbuf_error  (txbuf_error)
  );

  always #20 clk = ~clk; // 40 ns period

  //----------------------------------------------------------------------
  // Failure reporting and compare tasks
  //----------------------------------------------------------------------
  task automatic report_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
    $display("FAIL %s expected %08h actual %08h", name, expected, actual);
    $display("*** FAILED ***");
    $fatal(1);
  endtask

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("*** FAILED ***");
    $fatal(1);
  endtask

  task automatic check_rdata(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected)
      report_mismatch(name, expected, actual);
  endtask

  task automatic check_rresp(input nts_axil_pkg::axil_r_t actual);
    if (actual.resp !== nts_axil_pkg::AXIL_RESP_OKAY)
      report_mismatch("o_r.resp", {30'd0, nts_axil_pkg::AXIL_RESP_OKAY}, {30'd0, actual.resp});
  endtask

  task automatic check_bresp(input nts_axil_pkg::axil_b_t actual);
    if (actual.resp !== nts_axil_pkg::AXIL_RESP_OKAY)
      report_mismatch("o_b.resp", {30'd0, nts_axil_pkg::AXIL_RESP_OKAY}, {30'd0, actual.resp});
  endtask

  //----------------------------------------------------------------------
  // Random idle cycles and stimulus file
  //----------------------------------------------------------------------
  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic pick_idle(output int cycles);
    rng_state = lcg_next(rng_state);
    cycles = {30'd0, rng_state[31:30]}; // 0 to 3
  endtask

  task automatic load_stimulus();
    int          fd;
    int          fields;
    string       line;
    logic [7:0]  op;
    logic [31:0] arg_a;
    logic [31:0] arg_b;
    fd = $fopen("tb_stimulus.txt", "r");
    if (fd == 0)
      abort_run("Could not open tb_stimulus.txt");
    while ($fgets(line, fd) != 0)
    begin
      if (line.len() > 1 && line[0] != "#") // Skip comments and blank lines
      begin
        fields = $sscanf(line, "%c %h %h", op, arg_a, arg_b);
        if (fields != 3)
          abort_run($sformatf("Malformed stimulus line %s", line));
        op_q.push_back(op);
        arg_a_q.push_back(arg_a);
        arg_b_q.push_back(arg_b);
      end
    end
    $fclose(fd);
  endtask

  //----------------------------------------------------------------------
  // Bus operations
  //----------------------------------------------------------------------
  task automatic read_and_check(input logic [31:0] addr, input logic [31:0] expected);
    int                    waits;
    int                    idle;
    string                 data_name;
    nts_axil_pkg::axil_r_t first_r;
    data_name = $sformatf("o_r.data at %04h", addr[13:0]);
    @(posedge clk);
    arvalid <= 1'b1;
    araddr  <= addr[13:0];
    waits = 0;
    @(negedge clk);
    while (!arready)
    begin
      waits++;
      if (waits > TIMEOUT_CYCLES)
        abort_run("Timeout waiting for arready");
      @(negedge clk);
    end
    @(posedge clk); // AR handshake
    arvalid <= 1'b0;
    @(negedge clk);
    if (!rvalid)
      abort_run("rvalid did not rise one cycle after the AR handshake");
    first_r = r;
    check_rdata(data_name, expected, first_r.data);
    check_rresp(first_r);

    // Response must hold while rready is low
    pick_idle(idle);
    repeat (idle)
    begin
      @(negedge clk);
      if (!rvalid)
        abort_run("rvalid dropped before rready");
      if (arready)
        abort_run("arready high while a read response is pending");
      check_rdata(data_name, first_r.data, r.data);
    end
    @(posedge clk);
    rready <= 1'b1;
    @(posedge clk); // R handshake
    rready <= 1'b0;
    @(negedge clk);
    if (rvalid)
      abort_run("Second read response appeared after the handshake");
  endtask

  task automatic write_and_check(input logic [31:0] addr, input logic [31:0] data);
    int waits;
    int idle;
    @(posedge clk);
    awvalid <= 1'b1;
    wvalid  <= 1'b1;
    aw      <= '{addr: addr[13:0], prot: 3'b000};
    w       <= '{data: data, strb: 4'hf};
    waits = 0;
    @(negedge clk);
    while (!(awready && wready))
    begin
      waits++;
      if (waits > TIMEOUT_CYCLES)
        abort_run("Timeout waiting for awready and wready");
      @(negedge clk);
    end
    @(posedge clk); // AW and W handshake
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    @(negedge clk);
    if (!bvalid)
      abort_run("bvalid did not rise one cycle after the AW and W handshake");
    check_bresp(b);
    pick_idle(idle);
    repeat (idle)
    begin
      @(negedge clk);
      if (!bvalid)
        abort_run("bvalid dropped before bready");
      if (awready || wready)
        abort_run("awready or wready high while a write response is pending");
      check_bresp(b);
    end
    @(posedge clk);
    bready <= 1'b1;
    @(posedge clk); // B handshake
    bready <= 1'b0;
    @(negedge clk);
    if (bvalid)
      abort_run("Second write response appeared after the handshake");
  endtask

  // Both pulse trains start together and the shorter one ends early
  task automatic drive_error_burst(input int crypto_pulses, input int txbuf_pulses);
    int idx;
    int longest;
    longest = (crypto_pulses > txbuf_pulses) ? crypto_pulses : txbuf_pulses;
    for (idx = 0; idx < longest; idx++)
    begin
      @(posedge clk);
      crypto_error <= (idx < crypto_pulses);
      txbuf_error  <= (idx < txbuf_pulses);
    end
    @(posedge clk);
    crypto_error <= 1'b0;
    txbuf_error  <= 1'b0;
  endtask

  //----------------------------------------------------------------------
  // Main sequence
  //----------------------------------------------------------------------
  initial
  begin
    clk          = 1'b0;
    areset       = 1'b1;
    awvalid      = 1'b0;
    aw           = '0;
    wvalid       = 1'b0;
    w            = '0;
    bready       = 1'b0;
    arvalid      = 1'b0;
    araddr       = '0;
    rready       = 1'b0;
    crypto_error = 1'b0;
    txbuf_error  = 1'b0;
    rng_state    = 32'h4a37f2bf;

    load_stimulus();
    if (op_q.size() == 0)
      abort_run("Stimulus file holds no operations");

    repeat (10) @(posedge clk);
    areset <= 1'b0;

    foreach (op_q[i])
    begin
      case (op_q[i])
        "R":     read_and_check(arg_a_q[i], arg_b_q[i]);
        "W":     write_and_check(arg_a_q[i], arg_b_q[i]);
        "E":     drive_error_burst(int'(arg_a_q[i]), int'(arg_b_q[i]));
        default: abort_run($sformatf("Unknown stimulus operation %c", op_q[i]));
      endcase
    end

    repeat (2) @(posedge clk);
    $display("*** PASSED ***");
    $finish;
  end

endmodule

// ==== nts_engine_regs.sv ====
// Top level of the NTS engine register block
// AXI4-Lite slave, two error counters and the register decoder
`timescale 1ns/1ps

module nts_engine_regs #(
  parameter int AXI_ADDR_WIDTH = 14
) (
  input  logic                      i_clk,
  input  logic                      i_areset,

  input  logic                      i_awvalid,
  output logic                      o_awready,
  input  nts_axil_pkg::axil_aw_t    i_aw,
  input  logic                      i_wvalid,
  output logic                      o_wready,
  input  nts_axil_pkg::axil_w_t     i_w,
  output logic                      o_bvalid,
  input  logic                      i_bready,
  output nts_axil_pkg::axil_b_t     o_b,
  input  logic                      i_arvalid,
  output logic                      o_arready,
  input  nts_axil_pkg::axil_addr_t  i_araddr,
  output logic                      o_rvalid,
  input  logic                      i_rready,
  output nts_axil_pkg::axil_r_t     o_r,

  input  logic                      i_crypto_error, // Error pulse sources
  input  logic                      i_txbuf_error
);

  nts_regmap_pkg::api_req_t             req;
  logic [nts_axil_pkg::AXIL_DATA_W-1:0] rdata;
  nts_regmap_pkg::err_count_t           crypto_count;
  nts_regmap_pkg::err_count_t           txbuf_count;
  logic                                 crypto_snap;
  logic                                 txbuf_snap;

  //--------------------------------------------------------------------
  // Bus front end
  //--------------------------------------------------------------------
  nts_axil_slave #(
    .AXI_ADDR_WIDTH(AXI_ADDR_WIDTH)
  ) axil_slave (
    .i_clk     (i_clk),
    .i_areset  (i_areset),
    .i_awvalid (i_awvalid),
    .o_awready (o_awready),
    .i_aw      (i_aw),
    .i_wvalid  (i_wvalid),
    .o_wready  (o_wready),
    .i_w       (i_w),
    .o_bvalid  (o_bvalid),
    .i_bready  (i_bready),
    .o_b       (o_b),
    .i_arvalid (i_arvalid),
    .o_arready (o_arready),
    .i_araddr  (i_araddr),
    .o_rvalid  (o_rvalid),
    .i_rready  (i_rready),
    .o_r       (o_r),
    .o_req     (req),
    .i_rdata   (rdata)
  );

  //--------------------------------------------------------------------
  // Error counters
  //--------------------------------------------------------------------
  nts_error_counter crypto_counter (
    .i_clk    (i_clk),
    .i_areset (i_areset),
    .i_inc    (i_crypto_error),
    .i_snap   (crypto_snap),
    .o_count  (crypto_count)
  );

  nts_error_counter txbuf_counter (
    .i_clk    (i_clk),
    .i_areset (i_areset),
    .i_inc    (i_txbuf_error),
    .i_snap   (txbuf_snap),
    .o_count  (txbuf_count)
  );

  nts_api_regs api_regs (
    .i_req          (req),
    .i_crypto_count (crypto_count),
    .i_txbuf_count  (txbuf_count),
    .o_crypto_snap  (crypto_snap),
    .o_txbuf_snap   (txbuf_snap),
    .o_rdata        (rdata)
  );

endmodule

// ==== nts_api_regs.sv ====
// Register decoder for the engine and debug blocks
// Combinational read data and counter snapshot strobes
`timescale 1ns/1ps

module nts_api_regs (
  input  nts_regmap_pkg::api_req_t   i_req,
  input  nts_regmap_pkg::err_count_t i_crypto_count,
  input  nts_regmap_pkg::err_count_t i_txbuf_count,
  output logic                       o_crypto_snap,
  output logic                       o_txbuf_snap,
  output logic [31:0]                o_rdata
);

  logic [3:0] blk;     // Block select
  logic [7:0] offset;  // Register within block

  assign blk    = i_req.addr[11:8];
  assign offset = i_req.addr[7:0];

  //--------------------------------------------------------------------
  // Read decode
  //--------------------------------------------------------------------
  always_comb
  begin
    o_rdata       = 32'd0; // Unmapped reads return zero
    o_crypto_snap = 1'b0;
    o_txbuf_snap  = 1'b0;

    if (i_req.rd)
    begin
      case (blk)
        nts_regmap_pkg::BLOCK_ENGINE:
        begin
          case (offset)
            nts_regmap_pkg::ADDR_NAME0:   o_rdata = nts_regmap_pkg::CORE_NAME0;
            nts_regmap_pkg::ADDR_NAME1:   o_rdata = nts_regmap_pkg::CORE_NAME1;
            nts_regmap_pkg::ADDR_VERSION: o_rdata = nts_regmap_pkg::CORE_VERSION;
            nts_regmap_pkg::ADDR_CTRL:    o_rdata = 32'h0000_0001; // Engine enabled
            nts_regmap_pkg::ADDR_STATUS:  o_rdata = 32'h0000_0000;
            default:                      o_rdata = 32'd0;
          endcase
        end

        nts_regmap_pkg::BLOCK_DEBUG:
        begin
          case (offset)
            nts_regmap_pkg::ADDR_ERR_CRYPTO:
            begin
              o_rdata       = i_crypto_count.hi;
              o_crypto_snap = 1'b1;
            end
            nts_regmap_pkg::ADDR_ERR_CRYPTO_LO:
              o_rdata = i_crypto_count.snap;
            nts_regmap_pkg::ADDR_ERR_TXBUF:
            begin
              o_rdata      = i_txbuf_count.hi;
              o_txbuf_snap = 1'b1;
            end
            nts_regmap_pkg::ADDR_ERR_TXBUF_LO:
              o_rdata = i_txbuf_count.snap;
            default:
              o_rdata = 32'd0;
          endcase
        end

        // Cookie, clock and keymem blocks are not present
        default: o_rdata = 32'd0;
      endcase
    end
  end

endmodule

// ==== nts_error_counter.sv ====
// 64-bit error pulse counter
// Lower-word snapshot so both halves read from the same count
`timescale 1ns/1ps

module nts_error_counter (
  input  logic                       i_clk,
  input  logic                       i_areset,
  input  logic                       i_inc,   // One count per cycle high
  input  logic                       i_snap,  // Upper-word read in progress
  output nts_regmap_pkg::err_count_t o_count
);

  logic [63:0] count_q;
  logic [31:0] snap_q;

  //--------------------------------------------------------------------
  // Counter and snapshot
  //--------------------------------------------------------------------
  always_ff @(posedge i_clk or posedge i_areset)
  begin
    if (i_areset)
    begin
      count_q <= 64'd0;
      snap_q  <= 32'd0;
    end
    else
    begin
      if (i_inc)
        count_q <= count_q + 64'd1;

      // Takes the count before this cycle's increment
      if (i_snap)
        snap_q <= count_q[31:0];
    end
  end

  always_comb
  begin
    o_count.hi   = count_q[63:32];
    o_count.snap = snap_q;
  end

endmodule

// ==== nts_axil_slave.sv ====
// AXI4-Lite slave for the engine register block
// One read and one write in flight, each turned into a one-cycle request
`timescale 1ns/1ps

module nts_axil_slave #(
  parameter int AXI_ADDR_WIDTH = 14
) (
  input  logic                                  i_clk,
  input  logic                                  i_areset,

  input  logic                                  i_awvalid,
  output logic                                  o_awready,
  input  nts_axil_pkg::axil_aw_t                i_aw,

  input  logic                                  i_wvalid,
  output logic                                  o_wready,
  input  nts_axil_pkg::axil_w_t                 i_w,

  output logic                                  o_bvalid,
  input  logic                                  i_bready,
  output nts_axil_pkg::axil_b_t                 o_b,

  input  logic                                  i_arvalid,
  output logic                                  o_arready,
  input  nts_axil_pkg::axil_addr_t              i_araddr,

  output logic                                  o_rvalid,
  input  logic                                  i_rready,
  output nts_axil_pkg::axil_r_t                 o_r,

  output nts_regmap_pkg::api_req_t              o_req,
  input  logic [nts_axil_pkg::AXIL_DATA_W-1:0]  i_rdata
);

  localparam int WORD_ADDR_W = AXI_ADDR_WIDTH - 2;

  logic                                 ready_en;  // Low only in the reset cycle
  logic                                 rvalid_q;
  logic                                 bvalid_q;
  logic [nts_axil_pkg::AXIL_DATA_W-1:0] rdata_q;
  logic                                 rd_fire;
  logic                                 wr_fire;
  logic [WORD_ADDR_W-1:0]               ar_word;
  logic [WORD_ADDR_W-1:0]               aw_word;
  logic [nts_axil_pkg::AXIL_DATA_W-1:0] wmask;

  //--------------------------------------------------------------------
  // Handshakes
  //--------------------------------------------------------------------
  assign o_arready = ready_en & ~rvalid_q;
  assign o_awready = ready_en & ~bvalid_q;
  assign o_wready  = ready_en & ~bvalid_q;

  assign rd_fire = i_arvalid & o_arready;
  assign wr_fire = i_awvalid & i_wvalid & o_awready; // AW and W taken together

  assign ar_word = i_araddr[AXI_ADDR_WIDTH-1:2];
  assign aw_word = i_aw.addr[AXI_ADDR_WIDTH-1:2];

  // Byte strobes widened to a bit mask
  always_comb
  begin
    for (int i = 0; i < nts_axil_pkg::AXIL_STRB_W; i++)
    begin
      wmask[8*i +: 8] = {8{i_w.strb[i]}};
    end
  end

  // Writes never change state, so a read takes the shared address
  always_comb
  begin
    o_req.rd    = rd_fire;
    o_req.wr    = wr_fire;
    o_req.addr  = rd_fire ? nts_regmap_pkg::api_addr_t'(ar_word)
                          : nts_regmap_pkg::api_addr_t'(aw_word);
    o_req.wdata = i_w.data & wmask;
  end

  //--------------------------------------------------------------------
  // Response state
  //--------------------------------------------------------------------
  always_ff @(posedge i_clk or posedge i_areset)
  begin
    if (i_areset)
    begin
      ready_en <= 1'b0;
      rvalid_q <= 1'b0;
      bvalid_q <= 1'b0;
    end
    else
    begin
      ready_en <= 1'b1;
      if (rd_fire)
        rvalid_q <= 1'b1;
      else if (i_rready)
        rvalid_q <= 1'b0; // Held until taken
      if (wr_fire)
        bvalid_q <= 1'b1;
      else if (i_bready)
        bvalid_q <= 1'b0;
    end
  end

  // Read data captured at the AR handshake
  always_ff @(posedge i_clk)
  begin
    if (rd_fire)
      rdata_q <= i_rdata;
  end

  assign o_rvalid = rvalid_q;
  assign o_bvalid = bvalid_q;
  assign o_r      = '{data: rdata_q, resp: nts_axil_pkg::AXIL_RESP_OKAY};
  assign o_b      = '{resp: nts_axil_pkg::AXIL_RESP_OKAY};

endmodule

// ==== nts_regmap_pkg.sv ====
// Engine register map, identification words and internal request types
// Word address is {block[3:0], register[7:0]}

package nts_regmap_pkg;

  typedef logic [11:0] api_addr_t; // Word address

  //--------------------------------------------------------------------
  // Block selects, upper nibble of the word address
  //--------------------------------------------------------------------
  localparam logic [3:0] BLOCK_ENGINE = 4'h0;
  localparam logic [3:0] BLOCK_DEBUG  = 4'h3;

  //--------------------------------------------------------------------
  // Register offsets
  //--------------------------------------------------------------------
  localparam logic [7:0] ADDR_NAME0       = 8'h00;
  localparam logic [7:0] ADDR_NAME1       = 8'h01;
  localparam logic [7:0] ADDR_VERSION     = 8'h02;
  localparam logic [7:0] ADDR_CTRL        = 8'h08;
  localparam logic [7:0] ADDR_STATUS      = 8'h09;
  localparam logic [7:0] ADDR_ERR_CRYPTO  = 8'h20; // Upper word, latches snapshot
  localparam logic [7:0] ADDR_ERR_CRYPTO_LO = 8'h21;
  localparam logic [7:0] ADDR_ERR_TXBUF   = 8'h22; // Upper word, latches snapshot
  localparam logic [7:0] ADDR_ERR_TXBUF_LO  = 8'h23;

  localparam logic [31:0] CORE_NAME0   = 32'h4e_54_53_5f; // "NTS_"
  localparam logic [31:0] CORE_NAME1   = 32'h45_4e_47_4e; // "ENGN"
  localparam logic [31:0] CORE_VERSION = 32'h30_2e_30_31; // "0.01"

  // One-cycle request from the bus slave
  typedef struct packed {
    logic        rd;
    logic        wr;
    api_addr_t   addr;
    logic [31:0] wdata;
  } api_req_t;

  // Counter as seen by the decoder
  typedef struct packed {
    logic [31:0] hi;   // Upper half of live count
    logic [31:0] snap; // Lower half at last upper-word read
  } err_count_t;

endpackage

// ==== nts_axil_pkg.sv ====
// AXI4-Lite channel payload structs and widths
// Shared by the bus slave, the top level and the testbench

package nts_axil_pkg;

  localparam int AXIL_DATA_W = 32;
  localparam int AXIL_STRB_W = AXIL_DATA_W / 8;
  localparam int AXIL_ADDR_W = 14;

  localparam logic [1:0] AXIL_RESP_OKAY = 2'b00;

  typedef logic [AXIL_ADDR_W-1:0] axil_addr_t; // Byte address

  typedef struct packed {
    axil_addr_t addr;
    logic [2:0] prot;
  } axil_aw_t;

  typedef struct packed {
    logic [AXIL_DATA_W-1:0] data;
    logic [AXIL_STRB_W-1:0] strb;
  } axil_w_t;

  typedef struct packed {
    logic [1:0] resp;
  } axil_b_t;

  typedef struct packed {
    logic [AXIL_DATA_W-1:0] data;
    logic [1:0]             resp;
  } axil_r_t;

endpackage
